//--- Makefile
# Verilator flow for the Ising energy core
VERILATOR ?= verilator
TOP       := ising_energy_core_tb
FILELIST  := ising_energy_core.f
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
LOG       := sim.log
OBJDIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	-./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/ising_energy_core_chk.sv
/*
 * Ising energy core protocol checks
 * done pulse shape and latency, idle after reset,
 * result held between done pulses
 */
`timescale 1ns/1ps

module ising_energy_core_chk (
    input logic        clk_i,
    input logic        reset_i,
    input logic        start_i,
    input logic        busy_o,
    input logic        done_o,
    input logic [15:0] energy_o
);

    // done is one cycle wide
    done_single_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        done_o |=> !done_o)
        else $error("done_o held high for more than one cycle");

    // accepted start, done 18 edges later
    done_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        (start_i && !busy_o) |-> ##18 done_o)
        else $error("done_o missing 18 cycles after an accepted start");

    // nothing running right after reset
    idle_after_reset: assert property (@(posedge clk_i)
        reset_i |=> (!busy_o && !done_o))
        else $error("busy_o or done_o high after reset");

    // result only moves with done
    energy_held: assert property (@(posedge clk_i) disable iff (reset_i)
        !done_o |-> $stable(energy_o))
        else $error("energy_o changed outside a done cycle");

endmodule

bind ising_energy_core ising_energy_core_chk u_chk (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (start_i),
    .busy_o  (busy_o),
    .done_o  (done_o),
    .energy_o(energy_o)
);

//--- bench/ising_energy_core_tb.sv
/*
 * Ising energy core testbench
 * replays the records of the test data file: row records load the
 * coupling memory, run records start a sweep and compare the total
 * and the done timing against the expected values in the file
 */
`timescale 1ns/1ps

module ising_energy_core_tb;
    import ising_pkg::*;

    localparam int DONE_LATENCY = 18;  // start edge to done
    localparam int DONE_TIMEOUT = 100; // cycles before giving up

    logic      clk_i;
    logic      reset_i;
    logic      wr_en_i;
    spin_idx_t wr_addr_i;
    jrow_t     wr_jrow_i;
    hbias_t    wr_h_i;
    logic      start_i;
    spin_vec_t spin_i;
    hscale_t   hscaling_i;
    logic      busy_o;
    logic      done_o;
    energy_t   energy_o;

    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lfsr_q; // idle gap source

    ising_energy_core DUT (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wr_en_i   (wr_en_i),
        .wr_addr_i (wr_addr_i),
        .wr_jrow_i (wr_jrow_i),
        .wr_h_i    (wr_h_i),
        .start_i   (start_i),
        .spin_i    (spin_i),
        .hscaling_i(hscaling_i),
        .busy_o    (busy_o),
        .done_o    (done_o),
        .energy_o  (energy_o)
    );

    // 8 ns clock
    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ============================================================
    // helpers
    // ============================================================
    // galois lfsr, 32 bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
    endfunction

    task automatic check_value(input string msg, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic write_row(input spin_idx_t addr, input jrow_t jrow, input hbias_t h);
        @(posedge clk_i);
        wr_en_i   <= 1'b1;
        wr_addr_i <= addr;
        wr_jrow_i <= jrow;
        wr_h_i    <= h;
        @(posedge clk_i);
        wr_en_i   <= 1'b0; // one row per strobe
    endtask

    // mode 1 pulses a second start in the middle of the sweep
    task automatic run_sweep(input int id, input spin_vec_t spins, input hscale_t scale,
                             input energy_t expected, input int mode);
        int   gap;
        int   cycles;
        int   errs_before;
        logic got_done;
        errs_before = errors;
        gap = 0;
        for (int b = 0; b < 3; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            gap |= int'(lfsr_q[0]) << b;
        end
        repeat (gap) @(posedge clk_i);
        @(posedge clk_i);
        hscaling_i <= scale;
        start_i    <= 1'b1;
        spin_i     <= spins;
        got_done = 1'b0;
        cycles   = 0;
        while (!got_done && cycles < DONE_TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
            if (cycles == 1) start_i <= 1'b0;
            if (mode == 1 && cycles == 6) begin
                start_i <= 1'b1;   // must be ignored, busy
                spin_i  <= ~spins;
            end
            if (mode == 1 && cycles == 7) start_i <= 1'b0;
            @(negedge clk_i);
            got_done = done_o;
        end
        if (!got_done) begin
            $display("Timeout: test %0d saw no done_o within %0d cycles", id, DONE_TIMEOUT);
            errors++;
        end else begin
            check_value($sformatf("test %0d energy", id), 32'(energy_o), 32'(expected));
            check_value($sformatf("test %0d done latency", id), cycles, DONE_LATENCY);
            check_value($sformatf("test %0d busy at done", id), 32'(busy_o), 1);
            @(negedge clk_i);
            check_value($sformatf("test %0d done width", id), 32'(done_o), 0);
            check_value($sformatf("test %0d busy after done", id), 32'(busy_o), 0);
            if (mode == 1) begin
                // no second result from the ignored start
                for (int i = 0; i < 2 * DONE_LATENCY; i++) begin
                    @(negedge clk_i);
                    check_value($sformatf("test %0d extra done", id), 32'(done_o), 0);
                end
                check_value($sformatf("test %0d held energy", id), 32'(energy_o),
                            32'(expected));
            end
        end
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d: ok", id);
        end else begin
            $display("test %0d: failed", id);
            tests_failed++;
        end
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        int          fd;
        int          code;
        int          id;
        int          scale;
        int          mode;
        logic [7:0]  kind;
        logic [31:0] addr;
        logic [63:0] jrow;
        logic [31:0] hval;
        logic [31:0] spins;
        logic [31:0] expected;
        logic [8*256-1:0] line;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        lfsr_q       = 32'd85155;
        reset_i      = 1'b1;
        wr_en_i      = 1'b0;
        wr_addr_i    = '0;
        wr_jrow_i    = '0;
        wr_h_i       = '0;
        start_i      = 1'b0;
        spin_i       = '0;
        hscaling_i   = hscale_t'(1);
        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;

        // test 0, idle state after reset
        @(negedge clk_i);
        check_value("reset busy_o", 32'(busy_o), 0);
        check_value("reset done_o", 32'(done_o), 0);
        check_value("reset energy_o", 32'(energy_o), 0);
        tests_run++;
        if (errors == 0) begin
            $display("test 0: ok");
        end else begin
            $display("test 0: failed");
            tests_failed++;
        end

        fd = $fopen("bench/ising_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file bench/ising_testdata.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) break;
                if (kind == "#") begin
                    code = $fgets(line, fd); // rest of comment
                end else if (kind == "R") begin
                    code = $fscanf(fd, "%h %h %h", addr, jrow, hval);
                    write_row(spin_idx_t'(addr), jrow, hbias_t'(hval));
                end else if (kind == "T") begin
                    code = $fscanf(fd, "%d %h %d %h %d", id, spins, scale, expected, mode);
                    run_sweep(id, spin_vec_t'(spins), hscale_t'(scale),
                              energy_t'(expected), mode);
                end else begin
                    $display("Unknown record type in the test data file");
                    errors++;
                end
            end
            $fclose(fd);
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- bench/ising_testdata.txt
# R addr jrow(hex) h(hex)  loads one coupling memory row
# T id spins(hex) scale(dec) expected_total(hex) mode(0 plain, 1 second start mid-sweep)
R 0 7777777777777777 3
R 1 8888888888888888 e
R 2 7777777777777777 3
R 3 8888888888888888 e
R 4 7777777777777777 3
R 5 8888888888888888 e
R 6 7777777777777777 3
R 7 8888888888888888 e
R 8 7777777777777777 3
R 9 8888888888888888 e
R a 7777777777777777 3
R b 8888888888888888 e
R c 7777777777777777 3
R d 8888888888888888 e
R e 7777777777777777 3
R f 8888888888888888 e
# all ones, all zeros
T 1 ffff 1 ff90 0
T 2 0000 1 ff80 0
# mixed patterns
T 3 1234 1 ff9e 0
T 4 beef 1 fe0a 0
# bias scaling
T 5 5555 1 0030 0
T 6 5555 2 0058 0
T 7 5555 4 00a8 0
T 8 5555 8 0148 0
T 9 5555 16 0288 0
T 10 5555 3 0030 0
T 11 5555 0 0030 0
# ignored start during a sweep
T 12 beef 1 fe0a 1
# row 0 rewritten
R 0 1111111111111111 5
T 13 5555 1 0038 0
T 14 ffff 1 ff38 0

//--- ising_energy_core.f
logic/ising_pkg.sv
logic/adder_tree.sv
logic/partial_energy_calc.sv
logic/coupling_mem.sv
logic/energy_sweep_ctrl.sv
logic/ising_energy_core.sv
bench/ising_energy_core_chk.sv
bench/ising_energy_core_tb.sv

//--- logic/adder_tree.sv
/*
 * Recursive signed adder tree
 * sums N signed terms of DATAW bits into a SUMW bit signed result,
 * splitting the term list in half at every level. Purely combinational.
 */
`timescale 1ns/1ps

module adder_tree #(
    parameter int N     = 16, // number of terms
    parameter int DATAW = 8,  // width of one term
    parameter int SUMW  = 16  // width of the result
) (
    input  logic signed [N-1:0][DATAW-1:0] data_i, // terms, term 0 in the low bits
    output logic signed [SUMW-1:0]         sum_o   // signed total
);

    generate
        if (N == 1) begin : g_leaf
            // single term, just sign extend to the sum width
            assign sum_o = SUMW'($signed(data_i[0]));
        end else begin : g_node
            localparam int NL = N / 2;  // low half
            localparam int NR = N - NL; // high half, gets the odd term

            logic signed [SUMW-1:0] sum_lo; // low half subtotal
            logic signed [SUMW-1:0] sum_hi; // high half subtotal

            adder_tree #(
                .N    (NL),
                .DATAW(DATAW),
                .SUMW (SUMW)
            ) u_lo (
                .data_i(data_i[NL-1:0]),
                .sum_o (sum_lo)
            );

            adder_tree #(
                .N    (NR),
                .DATAW(DATAW),
                .SUMW (SUMW)
            ) u_hi (
                .data_i(data_i[N-1:NL]),
                .sum_o (sum_hi)
            );

            assign sum_o = sum_lo + sum_hi; // wraps at SUMW bits
        end
    endgenerate

endmodule

//--- logic/coupling_mem.sv
/*
 * Coupling memory
 * one J row and one h bias per spin, written through a plain strobe,
 * read back with one cycle of latency
 */
`timescale 1ns/1ps

module coupling_mem (
    input  logic                 clk_i,
    input  logic                 wr_en_i,   // write strobe, one row per edge
    input  ising_pkg::spin_idx_t wr_addr_i,
    input  ising_pkg::jrow_t     wr_jrow_i,
    input  ising_pkg::hbias_t    wr_h_i,
    input  ising_pkg::spin_idx_t rd_addr_i,
    output ising_pkg::jrow_t     rd_jrow_o, // row at rd_addr_i, one cycle later
    output ising_pkg::hbias_t    rd_h_o
);
    import ising_pkg::*;

    // ==========================================================
    // storage
    // ==========================================================
    jrow_t  j_mem [DATASPIN]; // coupling rows
    hbias_t h_mem [DATASPIN]; // local biases

    jrow_t  rd_jrow_q;
    hbias_t rd_h_q;

    // write port
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            j_mem[wr_addr_i] <= wr_jrow_i;
            h_mem[wr_addr_i] <= wr_h_i;
        end
    end

    // registered read, old data on a same address write
    always_ff @(posedge clk_i) begin
        rd_jrow_q <= j_mem[rd_addr_i];
        rd_h_q    <= h_mem[rd_addr_i];
    end

    assign rd_jrow_o = rd_jrow_q;
    assign rd_h_o    = rd_h_q;

endmodule

//--- logic/energy_sweep_ctrl.sv
/*
 * Energy sweep controller
 * latches the spins on start, issues one row read per cycle, lines up
 * the one-hot mask with the returned row and accumulates the partial
 * energies. The total is presented with a one-cycle done pulse.
 */
`timescale 1ns/1ps

module energy_sweep_ctrl (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 start_i,   // ignored while busy
    input  ising_pkg::spin_vec_t spin_i,    // valid with start_i
    input  ising_pkg::energy_t   partial_i, // from the calculator
    output ising_pkg::spin_idx_t rd_addr_o, // row address to memory
    output ising_pkg::spin_vec_t spin_o,    // latched spins
    output ising_pkg::spin_vec_t mask_o,    // one-hot on the returned row
    output logic                 busy_o,
    output logic                 done_o,
    output ising_pkg::energy_t   energy_o   // total held until the next done
);
    import ising_pkg::*;

    sweep_state_t state_q;
    spin_idx_t    idx_q;      // read index
    logic         rd_valid_q; // row from memory valid this cycle
    logic         last_q;     // that row is the last one
    spin_idx_t    mask_idx_q; // index of the row now on the memory output
    spin_vec_t    spin_q;
    energy_t      acc_q;      // running sum
    energy_t      acc_nxt;
    energy_t      energy_q;
    logic         done_q;

    assign acc_nxt = acc_q + partial_i; // wraps at 16 bits

    // ==========================================================
    // control and accumulation
    // ==========================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q    <= IDLE;
            idx_q      <= '0;
            rd_valid_q <= 1'b0;
            last_q     <= 1'b0;
            acc_q      <= '0;
            energy_q   <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q     <= 1'b0;
            rd_valid_q <= (state_q == SWEEP);  // memory answers one edge later
            last_q     <= (state_q == SWEEP) && (idx_q == spin_idx_t'(DATASPIN - 1));

            if (rd_valid_q) begin
                acc_q <= acc_nxt;
            end
            if (rd_valid_q && last_q) begin
                energy_q <= acc_nxt; // final sum goes out with done
                done_q   <= 1'b1;
            end

            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= SWEEP;
                        idx_q   <= '0;
                        acc_q   <= '0; // fresh sweep
                    end
                end
                SWEEP: begin
                    idx_q <= idx_q + 1'b1;
                    if (idx_q == spin_idx_t'(DATASPIN - 1)) begin
                        state_q <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (done_q) begin
                        state_q <= IDLE; // busy covers the done cycle
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // spin latch and mask alignment
    always_ff @(posedge clk_i) begin
        mask_idx_q <= idx_q; // follows the read latency
        if (state_q == IDLE && start_i) begin
            spin_q <= spin_i;
        end
    end

    assign rd_addr_o = idx_q;
    assign spin_o    = spin_q;
    assign mask_o    = spin_vec_t'(1) << mask_idx_q;
    assign busy_o    = (state_q != IDLE);
    assign done_o    = done_q;
    assign energy_o  = energy_q;

endmodule

//--- logic/ising_energy_core.sv
/*
 * Ising energy evaluator top level
 * coupling memory, sweep controller and partial energy calculator;
 * computes the total energy of a spin configuration in one sweep
 */
`timescale 1ns/1ps

module ising_energy_core (
    input  logic                 clk_i,
    input  logic                 reset_i,
    // coupling memory load
    input  logic                 wr_en_i,
    input  ising_pkg::spin_idx_t wr_addr_i,
    input  ising_pkg::jrow_t     wr_jrow_i,
    input  ising_pkg::hbias_t    wr_h_i,
    // sweep request
    input  logic                 start_i,
    input  ising_pkg::spin_vec_t spin_i,
    input  ising_pkg::hscale_t   hscaling_i, // stable during a sweep
    // result
    output logic                 busy_o,
    output logic                 done_o,
    output ising_pkg::energy_t   energy_o
);
    import ising_pkg::*;

    spin_idx_t rd_addr;        // controller to memory
    jrow_t     rd_jrow;        // row k
    hbias_t    rd_h;           // h[k]
    spin_vec_t spin_lat;       // latched spins
    spin_vec_t mask_vec;       // one-hot on k
    energy_t   partial_energy; // local energy of spin k

    // ==========================================================
    // storage
    // ==========================================================
    coupling_mem u_coupling_mem (
        .clk_i    (clk_i),
        .wr_en_i  (wr_en_i),
        .wr_addr_i(wr_addr_i),
        .wr_jrow_i(wr_jrow_i),
        .wr_h_i   (wr_h_i),
        .rd_addr_i(rd_addr),
        .rd_jrow_o(rd_jrow),
        .rd_h_o   (rd_h)
    );

    // ==========================================================
    // sequencing and accumulation
    // ==========================================================
    energy_sweep_ctrl u_sweep_ctrl (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .start_i  (start_i),
        .spin_i   (spin_i),
        .partial_i(partial_energy),
        .rd_addr_o(rd_addr),
        .spin_o   (spin_lat),
        .mask_o   (mask_vec),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .energy_o (energy_o)
    );

    partial_energy_calc u_partial_calc (
        .spin_i     (spin_lat),
        .spin_mask_i(mask_vec),
        .weight_i   (rd_jrow),
        .hbias_i    (rd_h),
        .hscaling_i (hscaling_i),
        .energy_o   (partial_energy)
    );

endmodule

//--- logic/ising_pkg.sv
/*
 * Ising energy evaluator shared definitions
 * widths, vector types and the sweep controller states
 */
package ising_pkg;

    // ==========================================================
    // sizes
    // ==========================================================
    localparam int DATASPIN         = 16; // spins per problem
    localparam int BITJ             = 4;  // coupling precision
    localparam int BITH             = 4;  // bias precision
    localparam int SCALING_BIT      = 5;  // h scaling factor width
    localparam int ENERGY_TOTAL_BIT = 16; // energy precision
    localparam int DATAJ            = DATASPIN * BITJ; // one packed J row
    // largest shift is 4, so bias grows by SCALING_BIT-1 bits
    localparam int MULTBIT          = BITH + SCALING_BIT - 1;
    localparam int IDXW             = $clog2(DATASPIN); // row address width

    // ==========================================================
    // vector types
    // ==========================================================
    typedef logic [DATASPIN-1:0]                spin_vec_t; // spins or one-hot mask
    typedef logic [DATAJ-1:0]                   jrow_t;     // J[k][j] at bits j*BITJ +: BITJ
    typedef logic signed [BITH-1:0]             hbias_t;    // two's complement bias
    typedef logic [SCALING_BIT-1:0]             hscale_t;   // unsigned factor
    typedef logic signed [ENERGY_TOTAL_BIT-1:0] energy_t;   // partial or total energy
    typedef logic [IDXW-1:0]                    spin_idx_t; // spin / row index

    // sweep controller
    typedef enum logic [1:0] {
        IDLE,  // waiting for start
        SWEEP, // issuing row reads
        DRAIN  // last rows still in flight
    } sweep_state_t;

endpackage

//--- logic/partial_energy_calc.sv
/*
 * Partial energy of one masked spin
 * signed terms from the couplings of row k and the scaled bias h[k],
 * summed by an adder tree and negated when spin k is 0.
 * Purely combinational.
 */
`timescale 1ns/1ps

module partial_energy_calc (
    input  ising_pkg::spin_vec_t spin_i,      // latched spin configuration
    input  ising_pkg::spin_vec_t spin_mask_i, // one-hot on spin k
    input  ising_pkg::jrow_t     weight_i,    // row k of J
    input  ising_pkg::hbias_t    hbias_i,     // h[k]
    input  ising_pkg::hscale_t   hscaling_i,  // bias scaling factor
    output ising_pkg::energy_t   energy_o     // local energy of spin k
);
    import ising_pkg::*;

    logic signed [DATASPIN-1:0][BITJ-1:0]    weight_2c;  // unpacked couplings
    logic signed [DATASPIN-1:0][MULTBIT-1:0] weight_ext; // sign extended couplings
    logic                                    masked_bit; // spin value at the mask
    logic signed [MULTBIT-1:0]               hbias_ext;
    logic signed [MULTBIT-1:0]               hbias_scaled;
    logic signed [DATASPIN-1:0][MULTBIT-1:0] term;       // one term per spin
    energy_t                                 energy_sum; // tree output

    // ==========================================================
    // coupling unpack, taken as two's complement
    // ==========================================================
    for (genvar j = 0; j < DATASPIN; j++) begin : g_unpack
        assign weight_2c[j]  = weight_i[j*BITJ +: BITJ];
        assign weight_ext[j] = {{(MULTBIT-BITJ){weight_2c[j][BITJ-1]}}, weight_2c[j]};
    end

    // pick spin k out of the vector
    always_comb begin
        masked_bit = 1'b0;
        for (int j = 0; j < DATASPIN; j++) begin
            if (spin_mask_i[j]) begin
                masked_bit = spin_i[j];
            end
        end
    end

    // ==========================================================
    // bias scaling, power of two factors only
    // ==========================================================
    assign hbias_ext = {{(MULTBIT-BITH){hbias_i[BITH-1]}}, hbias_i};

    always_comb begin
        case (hscaling_i)
            hscale_t'(1):  hbias_scaled = hbias_ext;
            hscale_t'(2):  hbias_scaled = hbias_ext <<< 1;
            hscale_t'(4):  hbias_scaled = hbias_ext <<< 2;
            hscale_t'(8):  hbias_scaled = hbias_ext <<< 3;
            hscale_t'(16): hbias_scaled = hbias_ext <<< 4;
            default:       hbias_scaled = hbias_ext; // 0, 3, ... no shift
        endcase
    end

    // ==========================================================
    // terms: bias at the mask, +/-J elsewhere
    // ==========================================================
    always_comb begin
        for (int j = 0; j < DATASPIN; j++) begin
            if (spin_mask_i[j]) begin
                term[j] = hbias_scaled;
            end else if (spin_i[j]) begin
                term[j] = weight_ext[j];  // spin 1 adds J
            end else begin
                term[j] = -weight_ext[j]; // spin 0 subtracts J
            end
        end
    end

    adder_tree #(
        .N    (DATASPIN),
        .DATAW(MULTBIT),
        .SUMW (ENERGY_TOTAL_BIT)
    ) u_adder_tree (
        .data_i(term),
        .sum_o (energy_sum)
    );

    // sign follows spin k
    assign energy_o = masked_bit ? energy_sum : -energy_sum;

endmodule
